/* sim.f */
source/axi2apb_pkg.sv
source/axi_chan_fifo.sv
source/apb_xfer_fsm.sv
source/axi2apb_bridge.sv
verif/apb_mem_model.sv
verif/tb_axi2apb.sv

/* Makefile */
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing --assert --timescale 1ns/10ps
TOP       ?= tb_axi2apb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: sim clean

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* verif/tb_axi2apb.sv */
`timescale 1ns/10ps

module tb_axi2apb;

    import axi2apb_pkg::*;

    localparam int unsigned NUM_TESTS  = 6;
    localparam int unsigned TEST_NS    = 4000;           // Budget per test
    localparam int unsigned SEED       = 32'hb69e9133;
    localparam int unsigned NUM_QUEUED = 2 * FIFO_DEPTH; // Fills B queue, then AW queue

    logic      ACLK = 1'b0;
    logic      ARESETn;
    logic      awvalid_i, awready_o, wvalid_i, wready_o, arvalid_i, arready_o;
    axi_id_t   awid_i, arid_i, bid_o, rid_o;
    axi_addr_t awaddr_i, araddr_i;
    axi_size_t awsize_i, arsize_i;
    axi_data_t wdata_i, rdata_o;
    axi_strb_t wstrb_i;
    logic      bready_i, bvalid_o, rready_i, rvalid_o;
    axi_resp_e bresp_o, rresp_o;
    logic      psel_o, penable_o, pwrite_o, pready_i, pslverr_i;
    apb_addr_t paddr_o;
    apb_data_t pwdata_o, prdata_i;

    string       test_name;
    int unsigned test_errs;
    int unsigned pass_count;
    int unsigned fail_count;

    always #4 ACLK = ~ACLK;

    axi2apb_bridge axi2apb_bridge_i (.*);

    apb_mem_model u_apb_mem (
        .ACLK, .ARESETn,
        .psel_i (psel_o), .penable_i (penable_o), .pwrite_i (pwrite_o),
        .paddr_i (paddr_o), .pwdata_i (pwdata_o), .prdata_o (prdata_i),
        .pready_o (pready_i), .pslverr_o (pslverr_i)
    );

    // ------------------------------------------------------------------------
    // Bookkeeping and compare tasks
    // ------------------------------------------------------------------------
    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            pass_count++;
            $display("[ok]   %s", test_name);
        end else begin
            fail_count++;
            $display("[fail] %s, %0d errors", test_name, test_errs);
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s: %s", test_name, msg);
        test_errs++;
    endtask

    task automatic check_data(input string what, input axi_data_t exp, input axi_data_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_resp(input string what, input axi_resp_e exp, input axi_resp_e act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %s, actual %s", test_name, what, exp.name(), act.name());
            test_errs++;
        end
    endtask

    task automatic check_id(input string what, input axi_id_t exp, input axi_id_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %b, actual %b", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    function automatic axi_data_t rand64();
        return {$urandom(), $urandom()};
    endfunction

    // Narrow accesses use the lane that address bit 2 picks
    function automatic axi_strb_t lane_strb(input axi_addr_t addr);
        return addr[2] ? 8'hF0 : 8'h0F;
    endfunction

    function automatic apb_data_t lane_word(input axi_addr_t addr, input axi_data_t data);
        return addr[2] ? data[63:32] : data[31:0];
    endfunction

    function automatic axi_data_t lane_place(input axi_addr_t addr, input apb_data_t word);
        return addr[2] ? {word, 32'h0} : {32'h0, word};
    endfunction

    function automatic axi_data_t mem_word(input axi_addr_t addr);
        return {32'h0, u_apb_mem.mem[addr[11:2]]};
    endfunction

    // ------------------------------------------------------------------------
    // AXI driver tasks
    // ------------------------------------------------------------------------
    task automatic axi_write(input axi_id_t id, input axi_addr_t addr, input axi_size_t size,
                             input axi_data_t data, input axi_strb_t strb);
        logic aw_done;
        logic w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(posedge ACLK);
        awvalid_i <= 1'b1;
        awid_i    <= id;
        awaddr_i  <= addr;
        awsize_i  <= size;
        wvalid_i  <= 1'b1;
        wdata_i   <= data;
        wstrb_i   <= strb;
        while (!(aw_done && w_done)) begin
            @(posedge ACLK);
            if (awvalid_i && awready_o) begin   // AW beat taken at this edge
                aw_done = 1'b1;
                awvalid_i <= 1'b0;
            end
            if (wvalid_i && wready_o) begin
                w_done = 1'b1;
                wvalid_i <= 1'b0;
            end
        end
    endtask

    task automatic wait_bresp(output axi_id_t id, output axi_resp_e resp);
        do begin
            @(posedge ACLK);
        end while (!(bvalid_o && bready_i));
        id   = bid_o;
        resp = bresp_o;
    endtask

    task automatic axi_read(input axi_id_t id, input axi_addr_t addr, input axi_size_t size,
                            output axi_id_t rid, output axi_data_t rdata,
                            output axi_resp_e rresp);
        @(posedge ACLK);
        arvalid_i <= 1'b1;
        arid_i    <= id;
        araddr_i  <= addr;
        arsize_i  <= size;
        do begin
            @(posedge ACLK);
        end while (!arready_o);
        arvalid_i <= 1'b0;
        do begin
            @(posedge ACLK);
        end while (!(rvalid_o && rready_i));
        rid   = rid_o;
        rdata = rdata_o;
        rresp = rresp_o;
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic test_reset_values();
        start_test("reset_values");
        @(posedge ACLK);
        check_flag("awready_o", 1'b1, awready_o);
        check_flag("wready_o", 1'b1, wready_o);
        check_flag("arready_o", 1'b1, arready_o);
        check_flag("bvalid_o", 1'b0, bvalid_o);
        check_flag("rvalid_o", 1'b0, rvalid_o);
        check_flag("psel_o", 1'b0, psel_o);
        check_flag("penable_o", 1'b0, penable_o);
        finish_test();
    endtask

    task automatic test_narrow_round_trip();
        axi_id_t   id;
        axi_resp_e resp;
        axi_data_t wdata;
        axi_data_t rdata;
        axi_addr_t addr;
        start_test("narrow_round_trip");
        addr  = 32'h0000_0104;   // Bit 2 set, upper lane
        wdata = rand64();
        axi_write(4'h3, addr, 3'd2, wdata, lane_strb(addr));
        wait_bresp(id, resp);
        check_id("bid", 4'h3, id);
        check_resp("bresp", OKAY, resp);
        check_data("memory", {32'h0, wdata[63:32]}, mem_word(addr));
        axi_read(4'h5, addr, 3'd2, id, rdata, resp);
        check_id("rid", 4'h5, id);
        check_resp("rresp", OKAY, resp);
        check_data("rdata", {wdata[63:32], 32'h0}, rdata);
        finish_test();
    endtask

    task automatic test_dword_round_trip();
        axi_id_t   id;
        axi_resp_e resp;
        axi_data_t wdata;
        axi_data_t rdata;
        start_test("dword_round_trip");
        wdata = rand64();
        axi_write(4'hA, 32'h0000_0180, SIZE_DWORD, wdata, 8'hFF);
        wait_bresp(id, resp);
        check_id("bid", 4'hA, id);
        check_resp("bresp", OKAY, resp);
        check_data("low word", {32'h0, wdata[31:0]}, mem_word(32'h180));
        check_data("high word", {32'h0, wdata[63:32]}, mem_word(32'h184));
        axi_read(4'hB, 32'h0000_0180, SIZE_DWORD, id, rdata, resp);
        check_id("rid", 4'hB, id);
        check_resp("rresp", OKAY, resp);
        check_data("rdata", wdata, rdata);
        finish_test();
    endtask

    task automatic test_half_skip();
        axi_id_t   id;
        axi_resp_e resp;
        axi_data_t wdata;
        axi_data_t rdata;
        apb_data_t old_hi;
        start_test("half_skip");
        old_hi = u_apb_mem.mem[10'h081];
        wdata  = rand64();
        axi_write(4'h1, 32'h0000_0200, SIZE_DWORD, wdata, 8'h0F);
        wait_bresp(id, resp);
        check_resp("bresp", OKAY, resp);
        axi_read(4'h2, 32'h0000_0200, SIZE_DWORD, id, rdata, resp);
        check_resp("rresp", OKAY, resp);
        check_data("rdata", {old_hi, wdata[31:0]}, rdata);
        finish_test();
    endtask

    task automatic test_error_response();
        axi_id_t   id;
        axi_resp_e resp;
        axi_data_t rdata;
        axi_data_t old;
        start_test("error_response");
        old = mem_word(32'h0F00);
        axi_write(4'h6, 32'h0000_0F00, 3'd2, rand64(), 8'h0F);
        wait_bresp(id, resp);
        check_id("bid", 4'h6, id);
        check_resp("bresp", SLVERR, resp);
        check_data("memory", old, mem_word(32'h0F00));
        axi_read(4'h7, 32'h0000_0F00, 3'd2, id, rdata, resp);
        check_id("rid", 4'h7, id);
        check_resp("rresp", SLVERR, resp);
        finish_test();
    endtask

    task automatic test_backpressure();
        axi_addr_t   addr_q [NUM_QUEUED];
        axi_data_t   data_q [NUM_QUEUED];
        axi_id_t     id;
        axi_resp_e   resp;
        axi_data_t   rdata;
        int unsigned cycles;
        start_test("backpressure");
        @(posedge ACLK);
        bready_i <= 1'b0;
        for (int i = 0; i < NUM_QUEUED; i++) begin
            addr_q[i] = 32'h0000_0300 + 4 * i;   // Alternating lanes
            data_q[i] = rand64();
            axi_write(axi_id_t'(i + 1), addr_q[i], 3'd2, data_q[i], lane_strb(addr_q[i]));
        end
        cycles = 0;
        while (awready_o && cycles < 64) begin
            @(posedge ACLK);
            cycles++;
        end
        if (awready_o) begin
            report_failure("awready_o stayed high with all queues full");
        end
        @(posedge ACLK);
        bready_i <= 1'b1;
        for (int i = 0; i < NUM_QUEUED; i++) begin
            wait_bresp(id, resp);
            check_id("bid", axi_id_t'(i + 1), id);
            check_resp("bresp", OKAY, resp);
        end
        for (int i = 0; i < NUM_QUEUED; i++) begin
            axi_read(4'hC, addr_q[i], 3'd2, id, rdata, resp);
            check_resp("rresp", OKAY, resp);
            check_data("rdata", lane_place(addr_q[i], lane_word(addr_q[i], data_q[i])), rdata);
        end
        finish_test();
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(SEED));
        pass_count = 0;
        fail_count = 0;
        ARESETn   = 1'b0;
        awvalid_i = 1'b0;
        awid_i    = '0;
        awaddr_i  = '0;
        awsize_i  = '0;
        wvalid_i  = 1'b0;
        wdata_i   = '0;
        wstrb_i   = '0;
        arvalid_i = 1'b0;
        arid_i    = '0;
        araddr_i  = '0;
        arsize_i  = '0;
        bready_i  = 1'b1;
        rready_i  = 1'b1;
        repeat (4) @(posedge ACLK);
        ARESETn <= 1'b1;
        test_reset_values();
        test_narrow_round_trip();
        test_dword_round_trip();
        test_half_skip();
        test_error_response();
        test_backpressure();
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * TEST_NS);
        $display("Watchdog expired in test %s, the DUT stopped responding", test_name);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* verif/apb_mem_model.sv */
`timescale 1ns/10ps

module apb_mem_model (
    input  logic                   ACLK,
    input  logic                   ARESETn,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  axi2apb_pkg::apb_addr_t paddr_i,
    input  axi2apb_pkg::apb_data_t pwdata_i,
    output axi2apb_pkg::apb_data_t prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o
);

    import axi2apb_pkg::*;

    localparam int unsigned MEM_WORDS = 1024;
    localparam apb_addr_t   ERR_BASE  = 12'hF00;   // Error window up to the top

    apb_data_t mem [MEM_WORDS];
    logic      slow_q;     // Current access gets one wait state
    logic      waited_q;   // Wait state already spent
    logic      access;
    logic      in_err;

    // Fill word mixes every address bit
    function automatic apb_data_t fill_word(input int unsigned idx);
        return (idx * 32'h9E37_79B1) ^ 32'hC3A5_0F1E;
    endfunction

    assign access    = psel_i & penable_i;
    assign in_err    = (paddr_i >= ERR_BASE);
    assign pready_o  = access & (~slow_q | waited_q);
    assign pslverr_o = pready_o & in_err;
    assign prdata_o  = mem[paddr_i[11:2]];

    always_ff @(posedge ACLK, negedge ARESETn) begin
        if (!ARESETn) begin
            slow_q   <= 1'b0;
            waited_q <= 1'b0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= fill_word(i);
            end
        end else if (pready_o) begin
            slow_q   <= ~slow_q;   // Every second access waits
            waited_q <= 1'b0;
            if (pwrite_i && !in_err) begin
                mem[paddr_i[11:2]] <= pwdata_i;
            end
        end else if (access) begin
            waited_q <= 1'b1;
        end
    end

endmodule

/* source/axi2apb_bridge.sv */
`timescale 1ns/10ps

module axi2apb_bridge (
    input  logic                   ACLK,
    input  logic                   ARESETn,
    // AW channel
    input  logic                   awvalid_i,
    input  axi2apb_pkg::axi_id_t   awid_i,
    input  axi2apb_pkg::axi_addr_t awaddr_i,
    input  axi2apb_pkg::axi_size_t awsize_i,
    output logic                   awready_o,
    // W channel
    input  logic                   wvalid_i,
    input  axi2apb_pkg::axi_data_t wdata_i,
    input  axi2apb_pkg::axi_strb_t wstrb_i,
    output logic                   wready_o,
    // AR channel
    input  logic                   arvalid_i,
    input  axi2apb_pkg::axi_id_t   arid_i,
    input  axi2apb_pkg::axi_addr_t araddr_i,
    input  axi2apb_pkg::axi_size_t arsize_i,
    output logic                   arready_o,
    // B channel
    input  logic                   bready_i,
    output logic                   bvalid_o,
    output axi2apb_pkg::axi_id_t   bid_o,
    output axi2apb_pkg::axi_resp_e bresp_o,
    // R channel
    input  logic                   rready_i,
    output logic                   rvalid_o,
    output axi2apb_pkg::axi_id_t   rid_o,
    output axi2apb_pkg::axi_data_t rdata_o,
    output axi2apb_pkg::axi_resp_e rresp_o,
    // APB
    output logic                   psel_o,
    output logic                   penable_o,
    output logic                   pwrite_o,
    output axi2apb_pkg::apb_addr_t paddr_o,
    output axi2apb_pkg::apb_data_t pwdata_o,
    input  axi2apb_pkg::apb_data_t prdata_i,
    input  logic                   pready_i,
    input  logic                   pslverr_i
);

    import axi2apb_pkg::*;

    // Queue heads towards the FSM
    logic                  aw_q_valid, aw_q_pop;
    logic [AW_ENTRY_W-1:0] aw_q_data;
    axi_id_t               aw_q_id;
    axi_addr_t             aw_q_addr;
    axi_size_t             aw_q_size;

    logic                  w_q_valid, w_q_pop;
    logic [W_ENTRY_W-1:0]  w_q_data;
    axi_data_t             w_q_wdata;
    axi_strb_t             w_q_strb;

    logic                  ar_q_valid, ar_q_pop;
    logic [AW_ENTRY_W-1:0] ar_q_data;   // Same layout as AW
    axi_id_t               ar_q_id;
    axi_addr_t             ar_q_addr;
    axi_size_t             ar_q_size;

    // Responses from the FSM
    logic                  b_push, b_room;
    axi_id_t               b_id;
    axi_resp_e             b_resp;
    logic [B_ENTRY_W-1:0]  b_out;

    logic                  r_push, r_room;
    axi_id_t               r_id;
    axi_data_t             r_data;
    axi_resp_e             r_resp;
    logic [R_ENTRY_W-1:0]  r_out;

    // ------------------------------------------------------------------------
    // Request queues
    // ------------------------------------------------------------------------
    axi_chan_fifo #(.WIDTH(AW_ENTRY_W), .DEPTH(FIFO_DEPTH)) u_aw_fifo (
        .ACLK, .ARESETn,
        .push_valid_i (awvalid_i),
        .push_data_i  ({awid_i, awaddr_i, awsize_i}),
        .push_ready_o (awready_o),
        .pop_valid_o  (aw_q_valid),
        .pop_data_o   (aw_q_data),
        .pop_ready_i  (aw_q_pop)
    );

    axi_chan_fifo #(.WIDTH(W_ENTRY_W), .DEPTH(FIFO_DEPTH)) u_w_fifo (
        .ACLK, .ARESETn,
        .push_valid_i (wvalid_i),
        .push_data_i  ({wdata_i, wstrb_i}),
        .push_ready_o (wready_o),
        .pop_valid_o  (w_q_valid),
        .pop_data_o   (w_q_data),
        .pop_ready_i  (w_q_pop)
    );

    axi_chan_fifo #(.WIDTH(AW_ENTRY_W), .DEPTH(FIFO_DEPTH)) u_ar_fifo (
        .ACLK, .ARESETn,
        .push_valid_i (arvalid_i),
        .push_data_i  ({arid_i, araddr_i, arsize_i}),
        .push_ready_o (arready_o),
        .pop_valid_o  (ar_q_valid),
        .pop_data_o   (ar_q_data),
        .pop_ready_i  (ar_q_pop)
    );

    assign {aw_q_id, aw_q_addr, aw_q_size} = aw_q_data;
    assign {w_q_wdata, w_q_strb}           = w_q_data;
    assign {ar_q_id, ar_q_addr, ar_q_size} = ar_q_data;

    // ------------------------------------------------------------------------
    // Response queues
    // ------------------------------------------------------------------------
    axi_chan_fifo #(.WIDTH(B_ENTRY_W), .DEPTH(FIFO_DEPTH)) u_b_fifo (
        .ACLK, .ARESETn,
        .push_valid_i (b_push),
        .push_data_i  ({b_id, b_resp}),
        .push_ready_o (b_room),
        .pop_valid_o  (bvalid_o),
        .pop_data_o   (b_out),
        .pop_ready_i  (bready_i)
    );

    axi_chan_fifo #(.WIDTH(R_ENTRY_W), .DEPTH(FIFO_DEPTH)) u_r_fifo (
        .ACLK, .ARESETn,
        .push_valid_i (r_push),
        .push_data_i  ({r_id, r_data, r_resp}),
        .push_ready_o (r_room),
        .pop_valid_o  (rvalid_o),
        .pop_data_o   (r_out),
        .pop_ready_i  (rready_i)
    );

    assign bid_o   = b_out[B_ENTRY_W-1 -: AXI_ID_W];
    assign bresp_o = axi_resp_e'(b_out[AXI_RESP_W-1:0]);
    assign rid_o   = r_out[R_ENTRY_W-1 -: AXI_ID_W];
    assign rdata_o = r_out[AXI_RESP_W +: AXI_DATA_W];
    assign rresp_o = axi_resp_e'(r_out[AXI_RESP_W-1:0]);

    // APB sequencing
    apb_xfer_fsm u_xfer_fsm (
        .ACLK, .ARESETn,
        .aw_valid_i (aw_q_valid), .aw_id_i (aw_q_id), .aw_addr_i (aw_q_addr),
        .aw_size_i  (aw_q_size),  .aw_pop_o (aw_q_pop),
        .w_valid_i  (w_q_valid),  .w_data_i (w_q_wdata), .w_strb_i (w_q_strb),
        .w_pop_o    (w_q_pop),
        .ar_valid_i (ar_q_valid), .ar_id_i (ar_q_id), .ar_addr_i (ar_q_addr),
        .ar_size_i  (ar_q_size),  .ar_pop_o (ar_q_pop),
        .b_ready_i  (b_room), .b_push_o (b_push), .b_id_o (b_id), .b_resp_o (b_resp),
        .r_ready_i  (r_room), .r_push_o (r_push), .r_id_o (r_id),
        .r_data_o   (r_data), .r_resp_o (r_resp),
        .psel_o, .penable_o, .pwrite_o, .paddr_o, .pwdata_o,
        .prdata_i, .pready_i, .pslverr_i
    );

endmodule

/* source/apb_xfer_fsm.sv */
`timescale 1ns/10ps

module apb_xfer_fsm (
    input  logic                   ACLK,
    input  logic                   ARESETn,
    // Write address queue head
    input  logic                   aw_valid_i,
    input  axi2apb_pkg::axi_id_t   aw_id_i,
    input  axi2apb_pkg::axi_addr_t aw_addr_i,
    input  axi2apb_pkg::axi_size_t aw_size_i,
    output logic                   aw_pop_o,
    // Write data queue head
    input  logic                   w_valid_i,
    input  axi2apb_pkg::axi_data_t w_data_i,
    input  axi2apb_pkg::axi_strb_t w_strb_i,
    output logic                   w_pop_o,
    // Read address queue head
    input  logic                   ar_valid_i,
    input  axi2apb_pkg::axi_id_t   ar_id_i,
    input  axi2apb_pkg::axi_addr_t ar_addr_i,
    input  axi2apb_pkg::axi_size_t ar_size_i,
    output logic                   ar_pop_o,
    // Write response queue
    input  logic                   b_ready_i,
    output logic                   b_push_o,
    output axi2apb_pkg::axi_id_t   b_id_o,
    output axi2apb_pkg::axi_resp_e b_resp_o,
    // Read response queue
    input  logic                   r_ready_i,
    output logic                   r_push_o,
    output axi2apb_pkg::axi_id_t   r_id_o,
    output axi2apb_pkg::axi_data_t r_data_o,
    output axi2apb_pkg::axi_resp_e r_resp_o,
    // APB requester
    output logic                   psel_o,
    output logic                   penable_o,
    output logic                   pwrite_o,
    output axi2apb_pkg::apb_addr_t paddr_o,
    output axi2apb_pkg::apb_data_t pwdata_o,
    input  axi2apb_pkg::apb_data_t prdata_i,
    input  logic                   pready_i,
    input  logic                   pslverr_i
);

    import axi2apb_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        RD_SETUP,
        RD_ACCESS,
        WR_SETUP,
        WR_ACCESS,
        RESP
    } xfer_state_e;

    xfer_state_e state_q;
    xfer_state_e state_d;
    logic        rd_xfer_q;    // Transaction in progress is a read
    logic        half_q;       // Selects the upper 32-bit half
    logic        more_q;       // Upper half still pending after this access
    logic        err_q;        // Sticky PSLVERR over the transaction
    apb_data_t   rdata_lo_q;
    apb_data_t   rdata_hi_q;

    logic        rd_go;
    logic        wr_go;
    logic        rd_dword;
    logic        wr_dword;
    logic        wr_lo_act;
    logic        wr_hi_act;
    logic        apb_done;
    axi_addr_t   base_addr;

    // ------------------------------------------------------------------------
    // Request selection, reads win over writes
    // ------------------------------------------------------------------------
    assign rd_go = ar_valid_i & r_ready_i;
    assign wr_go = ~rd_go & aw_valid_i & w_valid_i & b_ready_i;

    assign rd_dword = (ar_size_i == SIZE_DWORD);
    assign wr_dword = (aw_size_i == SIZE_DWORD);

    // A half takes part when the size or address selects it and a strobe is set
    assign wr_lo_act = (wr_dword | ~aw_addr_i[2]) & (|w_strb_i[3:0]);
    assign wr_hi_act = (wr_dword | aw_addr_i[2]) & (|w_strb_i[7:4]);

    assign apb_done = penable_o & pready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (rd_go) begin
                    state_d = RD_SETUP;
                end else if (wr_go) begin
                    state_d = (wr_lo_act | wr_hi_act) ? WR_SETUP : RESP;
                end
            end
            RD_SETUP:  state_d = RD_ACCESS;
            RD_ACCESS: begin
                if (pready_i) begin
                    state_d = more_q ? RD_SETUP : RESP;
                end
            end
            WR_SETUP:  state_d = WR_ACCESS;
            WR_ACCESS: begin
                if (pready_i) begin
                    state_d = more_q ? WR_SETUP : RESP;
                end
            end
            RESP:      state_d = IDLE;   // Response pushed, request popped
            default:   state_d = IDLE;
        endcase
    end

    // ------------------------------------------------------------------------
    // Control registers
    // ------------------------------------------------------------------------
    always_ff @(posedge ACLK, negedge ARESETn) begin
        if (!ARESETn) begin
            state_q   <= IDLE;
            rd_xfer_q <= 1'b0;
            half_q    <= 1'b0;
            more_q    <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE) begin
                err_q <= 1'b0;
                if (rd_go) begin
                    rd_xfer_q <= 1'b1;
                    half_q    <= rd_dword ? 1'b0 : ar_addr_i[2];
                    more_q    <= rd_dword;   // 64-bit reads take both halves
                end else if (wr_go) begin
                    rd_xfer_q <= 1'b0;
                    half_q    <= ~wr_lo_act;
                    more_q    <= wr_lo_act & wr_hi_act;
                end
            end else if (apb_done) begin
                err_q <= err_q | pslverr_i;
                if (more_q) begin
                    half_q <= 1'b1;          // Low word done, go on with the high word
                    more_q <= 1'b0;
                end
            end
        end
    end

    // Read data, halves not accessed stay zero
    always_ff @(posedge ACLK) begin
        if ((state_q == IDLE) && rd_go) begin
            rdata_lo_q <= '0;
            rdata_hi_q <= '0;
        end else if (apb_done && rd_xfer_q) begin
            if (half_q) begin
                rdata_hi_q <= prdata_i;
            end else begin
                rdata_lo_q <= prdata_i;
            end
        end
    end

    // ------------------------------------------------------------------------
    // APB outputs
    // ------------------------------------------------------------------------
    assign base_addr = rd_xfer_q ? ar_addr_i : aw_addr_i;

    assign psel_o    = (state_q == RD_SETUP) || (state_q == RD_ACCESS) ||
                       (state_q == WR_SETUP) || (state_q == WR_ACCESS);
    assign penable_o = (state_q == RD_ACCESS) || (state_q == WR_ACCESS);
    assign pwrite_o  = (state_q == WR_SETUP) || (state_q == WR_ACCESS);
    assign paddr_o   = {base_addr[APB_ADDR_W-1:3], 3'b000} +
                       (half_q ? apb_addr_t'(APB_WORD_BYTES) : '0);
    assign pwdata_o  = half_q ? w_data_i[63:32] : w_data_i[31:0];

    // Responses, room was checked before leaving IDLE
    assign b_push_o = (state_q == RESP) & ~rd_xfer_q;
    assign b_id_o   = aw_id_i;
    assign b_resp_o = err_q ? SLVERR : OKAY;
    assign r_push_o = (state_q == RESP) & rd_xfer_q;
    assign r_id_o   = ar_id_i;
    assign r_data_o = {rdata_hi_q, rdata_lo_q};
    assign r_resp_o = err_q ? SLVERR : OKAY;

    assign ar_pop_o = r_push_o;
    assign aw_pop_o = b_push_o;
    assign w_pop_o  = b_push_o;

    a_penable_in_sel: assert property (@(posedge ACLK) disable iff (!ARESETn)
        penable_o |-> psel_o);

    // Address and direction hold from setup until the completing cycle
    a_paddr_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
        psel_o && !apb_done |=> $stable(paddr_o) && $stable(pwrite_o));

endmodule

/* source/axi_chan_fifo.sv */
`timescale 1ns/10ps

module axi_chan_fifo #(
    parameter int unsigned WIDTH = 8,
    parameter int unsigned DEPTH = 4
) (
    input  logic             ACLK,
    input  logic             ARESETn,
    // Push side
    input  logic             push_valid_i,
    input  logic [WIDTH-1:0] push_data_i,
    output logic             push_ready_o,
    // Pop side
    output logic             pop_valid_o,
    output logic [WIDTH-1:0] pop_data_o,
    input  logic             pop_ready_i
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;   // Occupancy
    logic             push;
    logic             pop;

    assign push_ready_o = (count_q != CNT_W'(DEPTH));
    assign pop_valid_o  = (count_q != '0);
    assign pop_data_o   = mem[rd_ptr_q];   // Registered entry, no fall-through

    assign push = push_valid_i & push_ready_o;
    assign pop  = pop_valid_o & pop_ready_i;

    // ------------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------------
    always_ff @(posedge ACLK, negedge ARESETn) begin
        if (!ARESETn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                if (wr_ptr_q == PTR_W'(DEPTH - 1)) begin
                    wr_ptr_q <= '0;   // Wrap around
                end else begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr_q == PTR_W'(DEPTH - 1)) begin
                    rd_ptr_q <= '0;
                end else begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end
            count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // Storage
    always_ff @(posedge ACLK) begin
        if (push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    a_count_bound: assert property (@(posedge ACLK) disable iff (!ARESETn)
        count_q <= CNT_W'(DEPTH));

    // A stalled head entry must not change under the consumer
    a_head_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
        pop_valid_o && !pop_ready_i |=> $stable(pop_data_o));

endmodule

/* source/axi2apb_pkg.sv */
package axi2apb_pkg;

    // ------------------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------------------
    localparam int unsigned AXI_ADDR_W = 32;
    localparam int unsigned APB_ADDR_W = 12;  // Low part of the AXI address
    localparam int unsigned AXI_ID_W   = 4;
    localparam int unsigned AXI_DATA_W = 64;
    localparam int unsigned APB_DATA_W = 32;
    localparam int unsigned AXI_STRB_W = AXI_DATA_W / 8;
    localparam int unsigned AXI_SIZE_W = 3;
    localparam int unsigned AXI_RESP_W = 2;

    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [AXI_ID_W-1:0]   axi_id_t;
    typedef logic [AXI_DATA_W-1:0] axi_data_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;
    typedef logic [AXI_STRB_W-1:0] axi_strb_t;
    typedef logic [AXI_SIZE_W-1:0] axi_size_t;

    // AXI response codes, the bridge only returns OKAY and SLVERR
    typedef enum logic [AXI_RESP_W-1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // ------------------------------------------------------------------------
    // Bridge constants
    // ------------------------------------------------------------------------
    localparam int unsigned FIFO_DEPTH     = 4;     // Entries per channel queue
    localparam axi_size_t   SIZE_DWORD     = 3'd3;  // 8-byte transfer
    localparam int unsigned APB_WORD_BYTES = 4;     // Offset of the upper half

    // Queue entry layouts, most significant field first
    // AW / AR : {id, addr, size}
    // W       : {data, strb}
    // B       : {id, resp}
    // R       : {id, data, resp}
    localparam int unsigned AW_ENTRY_W = AXI_ID_W + AXI_ADDR_W + AXI_SIZE_W;
    localparam int unsigned W_ENTRY_W  = AXI_DATA_W + AXI_STRB_W;
    localparam int unsigned B_ENTRY_W  = AXI_ID_W + AXI_RESP_W;
    localparam int unsigned R_ENTRY_W  = AXI_ID_W + AXI_DATA_W + AXI_RESP_W;

endpackage
